/* bios_rom.sv */
// 64 KB BIOS array, filled through the download port
// the CPU cannot write it, mem_wr_n is never looked at
// CPU reads while downloading give the byte at the download address

`timescale 1ns/1ps

`include "periph_config.svh"

module bios_rom (
    input  logic                 clock,
    periph_bus_if.slave          bus,
    input  logic                 sel_i,
    input  logic                 dl_active_i,
    input  logic                 dl_wr_i,
    input  periph_pkg::rom_addr_t dl_addr_i,
    input  periph_pkg::data_t    dl_data_i,
    output periph_pkg::data_t    rdata_o
);
    import periph_pkg::*;

    localparam int DEPTH = 2 ** `ROM_AW;

    data_t     mem [0:DEPTH-1];
    rom_addr_t rom_addr;
    logic      rom_en;
    logic      rom_we;

    // download owns the array while it runs
    assign rom_addr = dl_active_i ? dl_addr_i : bus.addr[`ROM_AW-1:0];
    assign rom_en   = dl_active_i || sel_i;
    assign rom_we   = dl_active_i && dl_wr_i;

    always_ff @(posedge clock) begin
        if (rom_en) begin
            if (rom_we) begin
                mem[rom_addr] <= dl_data_i;
            end
            rdata_o <= mem[rom_addr];
        end
    end

endmodule

/* bus_control.sv */
// address decode and read-back mux of the bus glue
// memory selects ignore the strobes, the memories gate on them
// read data of the memories must already be registered by the caller

`timescale 1ns/1ps

`include "periph_config.svh"

module bus_control (
    periph_bus_if.slave          bus,
    output logic                 ram_sel_o,
    output logic                 vram_sel_o,
    output logic                 rom_sel_o,
    output logic                 kbd_sel_o,
    input  periph_pkg::data_t    ram_rdata_i,
    input  periph_pkg::data_t    vram_rdata_i,
    input  periph_pkg::data_t    rom_rdata_i,
    input  periph_pkg::data_t    kbd_data_i,
    input  periph_pkg::data_t    kbd_ctrl_i,
    output periph_pkg::data_t    data_o,
    output logic                 data_valid_o
);
    import periph_pkg::*;

    logic      cpu_cycle;
    logic      io_page;
    logic      kbd_data_hit;
    logic      kbd_ctrl_hit;
    read_src_e read_src;

    assign cpu_cycle = ~bus.aen_n;

    // ISA style 10 bit I/O decode, so 0x160 aliases nothing here
    assign io_page      = (bus.addr[9:8] == 2'b00);
    assign kbd_data_hit = io_page && (bus.addr[7:0] == `KBD_DATA_PORT);
    assign kbd_ctrl_hit = io_page && (bus.addr[7:0] == `KBD_CTRL_PORT);

    // memory windows
    assign ram_sel_o  = cpu_cycle && (bus.addr < `RAM_TOP);
    assign vram_sel_o = cpu_cycle && (bus.addr[19:15] == `VRAM_BASE_HI);
    assign rom_sel_o  = cpu_cycle && (bus.addr[19:16] == `ROM_BASE_HI);
    assign kbd_sel_o  = cpu_cycle && (kbd_data_hit || kbd_ctrl_hit);

    // fixed priority, keyboard first then the memories
    always_comb begin
        if (kbd_sel_o && kbd_data_hit && !bus.io_rd_n) begin
            read_src = SRC_KBD_DATA;
        end
        else if (kbd_sel_o && kbd_ctrl_hit && !bus.io_rd_n) begin
            read_src = SRC_KBD_CTRL;
        end
        else if (vram_sel_o && !bus.mem_rd_n) begin
            read_src = SRC_VRAM;
        end
        else if (rom_sel_o && !bus.mem_rd_n) begin
            read_src = SRC_ROM;
        end
        else if (ram_sel_o && !bus.mem_rd_n) begin
            read_src = SRC_RAM;
        end
        else begin
            read_src = SRC_NONE;
        end
    end

    always_comb begin
        case (read_src)
            SRC_KBD_DATA: data_o = kbd_data_i;
            SRC_KBD_CTRL: data_o = kbd_ctrl_i;
            SRC_VRAM:     data_o = vram_rdata_i;
            SRC_ROM:      data_o = rom_rdata_i;
            SRC_RAM:      data_o = ram_rdata_i;
            default:      data_o = '0;
        endcase
    end

    assign data_valid_o = (read_src != SRC_NONE);

endmodule

/* byte_ram.sv */
// single port byte RAM on the CPU bus
// read data shows up one clock after the address
// a read in the write cycle returns the old byte

`timescale 1ns/1ps

module byte_ram #(
    parameter int AW = 15
) (
    input  logic                 clock,
    periph_bus_if.slave          bus,
    input  logic                 sel_i,
    output periph_pkg::data_t    rdata_o
);
    import periph_pkg::*;

    localparam int DEPTH = 2 ** AW;

    data_t          mem [0:DEPTH-1];
    logic  [AW-1:0] word_addr;

    // low bits only, the decoder already matched the window
    assign word_addr = bus.addr[AW-1:0];

    always_ff @(posedge clock) begin
        if (sel_i) begin
            if (!bus.mem_wr_n) begin
                mem[word_addr] <= bus.wdata;
            end
            rdata_o <= mem[word_addr];
        end
    end

endmodule

/* kbd_port.sv */
// keyboard scan code latch and control register at 0x60/0x61
// one code is held at a time, later strobes are dropped until cleared
// the irq is simply the latch full flag

`timescale 1ns/1ps

`include "periph_config.svh"

module kbd_port (
    input  logic                 clock,
    input  logic                 reset,
    periph_bus_if.slave          bus,
    input  logic                 sel_i,
    input  periph_pkg::data_t    keycode_i,
    input  logic                 keycode_stb_i,
    output periph_pkg::data_t    kbd_data_o,
    output periph_pkg::data_t    kbd_ctrl_o,
    output logic                 kbd_irq_o
);
    import periph_pkg::*;

    data_t scan_code;
    data_t ctrl_reg;
    logic  latch_full;
    logic  ctrl_wr;
    logic  latch_clear;
    logic  latch_load;

    // 0x61 is the odd port of the pair
    assign ctrl_wr     = sel_i && !bus.io_wr_n && bus.addr[0];
    assign latch_clear = ctrl_wr && bus.wdata[`KBD_CLEAR_BIT];
    assign latch_load  = keycode_stb_i && !latch_full;

    always_ff @(posedge clock) begin
        if (reset) begin
            ctrl_reg   <= '0;
            latch_full <= 1'b0;
        end
        else begin
            if (ctrl_wr) begin
                ctrl_reg <= bus.wdata;
            end
            if (latch_load) begin
                latch_full <= 1'b1;
            end
            else if (latch_clear) begin
                latch_full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (latch_load) begin
            scan_code <= keycode_i;
        end
    end

    // empty latch reads as zero
    assign kbd_data_o = latch_full ? scan_code : '0;
    assign kbd_ctrl_o = ctrl_reg;
    assign kbd_irq_o  = latch_full;

endmodule

/* periph_bus_if.sv */
// CPU side bus of the glue logic
// all strobes are active low, as on the XT bus

`timescale 1ns/1ps

interface periph_bus_if;
    import periph_pkg::*;

    addr_t addr;
    data_t wdata;
    logic  io_rd_n;
    logic  io_wr_n;
    logic  mem_rd_n;
    logic  mem_wr_n;
    // low while the CPU owns the address lines
    logic  aen_n;

    // top level drives the bus from its pins
    modport master (
        output addr,
        output wdata,
        output io_rd_n,
        output io_wr_n,
        output mem_rd_n,
        output mem_wr_n,
        output aen_n
    );

    // decoder and the memories only look
    modport slave (
        input addr,
        input wdata,
        input io_rd_n,
        input io_wr_n,
        input mem_rd_n,
        input mem_wr_n,
        input aen_n
    );

endinterface

/* periph_config.svh */
// memory map and port constants for the XT bus glue
// windows are compared on the upper address bits only
// I/O decode looks at 10 address bits like a plain ISA card

`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// bus widths
`define PERIPH_ADDR_W 20
`define PERIPH_DATA_W 8

// system RAM occupies 00000 up to this address
`define RAM_TOP 20'hA0000

// text buffer at B0000-B7FFF, matched on addr[19:15]
`define VRAM_BASE_HI 5'b10110

// BIOS at F0000-FFFFF, matched on addr[19:16]
`define ROM_BASE_HI 4'hF

// array address widths
`define RAM_AW 20
`define VRAM_AW 15
`define ROM_AW 16

// keyboard ports in the low I/O page
`define KBD_DATA_PORT 8'h60
`define KBD_CTRL_PORT 8'h61
`define KBD_CLEAR_BIT 7

`endif

/* periph_pkg.sv */
// shared types of the bus glue
// widths come from the config header

package periph_pkg;

`include "periph_config.svh"

    // CPU address and data
    typedef logic [`PERIPH_ADDR_W-1:0] addr_t;
    typedef logic [`PERIPH_DATA_W-1:0] data_t;

    // download port address into the BIOS array
    typedef logic [`ROM_AW-1:0] rom_addr_t;

    // who owns the read data bus, in priority order
    typedef enum logic [2:0] {
        SRC_NONE,
        SRC_KBD_DATA,
        SRC_KBD_CTRL,
        SRC_VRAM,
        SRC_ROM,
        SRC_RAM
    } read_src_e;

endpackage

/* periph_top.sv */
// memory and keyboard glue of an XT class board, one clock domain
// RAM 00000-9FFFF, text buffer B0000-B7FFF, BIOS F0000-FFFFF
// no wait states, read data of the memories lags the address by a clock

`timescale 1ns/1ps

`include "periph_config.svh"

module periph_top (
    input  logic                  clock,
    input  logic                  reset,
    input  periph_pkg::addr_t     address_i,
    input  periph_pkg::data_t     data_i,
    input  logic                  io_rd_n_i,
    input  logic                  io_wr_n_i,
    input  logic                  mem_rd_n_i,
    input  logic                  mem_wr_n_i,
    input  logic                  aen_n_i,
    input  logic                  dl_active_i,
    input  logic                  dl_wr_i,
    input  periph_pkg::rom_addr_t dl_addr_i,
    input  periph_pkg::data_t     dl_data_i,
    input  periph_pkg::data_t     keycode_i,
    input  logic                  keycode_stb_i,
    output periph_pkg::data_t     data_o,
    output logic                  data_valid_o,
    output logic                  kbd_irq_o
);
    import periph_pkg::*;

    logic  ram_sel;
    logic  vram_sel;
    logic  rom_sel;
    logic  kbd_sel;
    data_t ram_rdata;
    data_t vram_rdata;
    data_t rom_rdata;
    data_t kbd_data;
    data_t kbd_ctrl;

    periph_bus_if bus_if ();

    // pins onto the shared bus
    assign bus_if.addr     = address_i;
    assign bus_if.wdata    = data_i;
    assign bus_if.io_rd_n  = io_rd_n_i;
    assign bus_if.io_wr_n  = io_wr_n_i;
    assign bus_if.mem_rd_n = mem_rd_n_i;
    assign bus_if.mem_wr_n = mem_wr_n_i;
    assign bus_if.aen_n    = aen_n_i;

    bus_control u_bus_control (
        .bus          (bus_if.slave),
        .ram_sel_o    (ram_sel),
        .vram_sel_o   (vram_sel),
        .rom_sel_o    (rom_sel),
        .kbd_sel_o    (kbd_sel),
        .ram_rdata_i  (ram_rdata),
        .vram_rdata_i (vram_rdata),
        .rom_rdata_i  (rom_rdata),
        .kbd_data_i   (kbd_data),
        .kbd_ctrl_i   (kbd_ctrl),
        .data_o       (data_o),
        .data_valid_o (data_valid_o)
    );

    // 640 KB system RAM
    byte_ram #(.AW(`RAM_AW)) u_ram (
        .clock   (clock),
        .bus     (bus_if.slave),
        .sel_i   (ram_sel),
        .rdata_o (ram_rdata)
    );

    // monochrome text buffer, CPU port only
    byte_ram #(.AW(`VRAM_AW)) u_vram (
        .clock   (clock),
        .bus     (bus_if.slave),
        .sel_i   (vram_sel),
        .rdata_o (vram_rdata)
    );

    bios_rom u_bios_rom (
        .clock       (clock),
        .bus         (bus_if.slave),
        .sel_i       (rom_sel),
        .dl_active_i (dl_active_i),
        .dl_wr_i     (dl_wr_i),
        .dl_addr_i   (dl_addr_i),
        .dl_data_i   (dl_data_i),
        .rdata_o     (rom_rdata)
    );

    kbd_port u_kbd_port (
        .clock         (clock),
        .reset         (reset),
        .bus           (bus_if.slave),
        .sel_i         (kbd_sel),
        .keycode_i     (keycode_i),
        .keycode_stb_i (keycode_stb_i),
        .kbd_data_o    (kbd_data),
        .kbd_ctrl_o    (kbd_ctrl),
        .kbd_irq_o     (kbd_irq_o)
    );

endmodule

/* src.f */
+incdir+.
periph_pkg.sv
periph_bus_if.sv
bus_control.sv
byte_ram.sv
bios_rom.sv
kbd_port.sv
periph_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_periph.sv

/* tb_checker.sv */
// compares the DUT outputs with the expected values of one table row
// a row is sampled on the falling edge of its last cycle

`timescale 1ns/1ps

module tb_checker #(
    parameter int NAME_CHARS = 20
) (
    input  logic                    clock_i,
    input  logic                    start_i,
    input  int                      cycles_i,
    input  int                      row_i,
    input  logic [8*NAME_CHARS-1:0] name_i,
    input  logic [7:0]              exp_data_i,
    input  logic                    exp_valid_i,
    input  logic                    exp_irq_i,
    input  logic [7:0]              data_i,
    input  logic                    data_valid_i,
    input  logic                    kbd_irq_i,
    output int                      data_errs_o,
    output int                      valid_errs_o,
    output int                      irq_errs_o,
    output int                      checks_o
);

    logic [8*NAME_CHARS-1:0] cur_name;
    logic [7:0]              cur_exp_data;
    logic                    cur_exp_valid;
    logic                    cur_exp_irq;
    int                      cur_row;
    int                      cycles_left;

    initial begin
        cycles_left  = 0;
        data_errs_o  = 0;
        valid_errs_o = 0;
        irq_errs_o   = 0;
        checks_o     = 0;
    end

    task automatic compare_outputs();
        checks_o = checks_o + 1;
        if (data_i !== cur_exp_data) begin
            data_errs_o = data_errs_o + 1;
            $display("ERR %0s: data_o expected %02h actual %02h",
                     cur_name, cur_exp_data, data_i);
        end
        if (data_valid_i !== cur_exp_valid) begin
            valid_errs_o = valid_errs_o + 1;
            $display("row %0d (%0s): data_valid_o should be %b but is %b",
                     cur_row, cur_name, cur_exp_valid, data_valid_i);
        end
        if (kbd_irq_i !== cur_exp_irq) begin
            irq_errs_o = irq_errs_o + 1;
            $display("row %0d (%0s): kbd_irq_o should be %b but is %b",
                     cur_row, cur_name, cur_exp_irq, kbd_irq_i);
        end
    endtask

    // latch the row on its first falling edge, compare on its last
    always @(negedge clock_i) begin
        if (start_i) begin
            cur_row       = row_i;
            cur_name      = name_i;
            cur_exp_data  = exp_data_i;
            cur_exp_valid = exp_valid_i;
            cur_exp_irq   = exp_irq_i;
            cycles_left   = cycles_i;
        end
        if (cycles_left > 0) begin
            cycles_left = cycles_left - 1;
            if (cycles_left == 0) begin
                compare_outputs();
            end
        end
    end

endmodule

/* tb_clock_gen.sv */
// clock and reset source for the testbench
// reset is synchronous and active high, released just after a rising edge

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 3,
    parameter int DRIVE_DELAY  = 1
) (
    output logic clock_o,
    output logic reset_o
);

    initial begin
        clock_o = 1'b0;
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock_o);
        #DRIVE_DELAY;
        reset_o = 1'b0;
    end

    always #(PERIOD_NS / 2) clock_o = ~clock_o;

endmodule

/* tb_periph.sv */
// testbench for the XT memory and keyboard glue
// steps through a fixed table of bus operations, one row at a time
// expected irq of a row is the level seen during that row

`timescale 1ns/1ps

module tb_periph;

    localparam int CLK_PERIOD  = 4;
    localparam int RESET_CYC   = 3;
    localparam int DRIVE_DELAY = 1;
    localparam int NAME_CHARS  = 20;
    localparam int MAX_ROWS    = 64;
    localparam int WD_MARGIN   = 40;
    localparam logic [31:0] LFSR_SEED = 32'habed_4e01;
    // x^32 + x^22 + x^2 + x + 1, right shifting form
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    localparam int OP_IDLE     = 0;
    localparam int OP_ROM_LOAD = 1;
    localparam int OP_MEM_WR   = 2;
    localparam int OP_MEM_RD   = 3;
    localparam int OP_IO_WR    = 4;
    localparam int OP_IO_RD    = 5;
    localparam int OP_KEY      = 6;

    logic        clock;
    logic        reset;
    logic [19:0] address;
    logic [7:0]  wdata;
    logic        io_rd_n;
    logic        io_wr_n;
    logic        mem_rd_n;
    logic        mem_wr_n;
    logic        aen_n;
    logic        dl_active;
    logic        dl_wr;
    logic [15:0] dl_addr;
    logic [7:0]  dl_data;
    logic [7:0]  keycode;
    logic        keycode_stb;
    logic [7:0]  data_out;
    logic        data_valid;
    logic        kbd_irq;

    // row currently handed to the checker
    logic                    chk_start;
    int                      chk_cycles;
    int                      chk_row;
    logic [8*NAME_CHARS-1:0] chk_name;
    logic [7:0]              chk_exp_data;
    logic                    chk_exp_valid;
    logic                    chk_exp_irq;
    int                      data_errs;
    int                      valid_errs;
    int                      irq_errs;
    int                      checks;

    // stimulus table
    logic [8*NAME_CHARS-1:0] tab_name [0:MAX_ROWS-1];
    int                      tab_op [0:MAX_ROWS-1];
    logic [19:0]             tab_addr [0:MAX_ROWS-1];
    logic [7:0]              tab_data [0:MAX_ROWS-1];
    logic                    tab_aen_hi [0:MAX_ROWS-1];
    logic [7:0]              tab_exp_data [0:MAX_ROWS-1];
    logic                    tab_exp_valid [0:MAX_ROWS-1];
    logic                    tab_exp_irq [0:MAX_ROWS-1];
    int                      row_count;
    logic                    table_ready;
    logic [31:0]             lfsr_state;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYC),
        .DRIVE_DELAY  (DRIVE_DELAY)
    ) u_clock_gen (
        .clock_o (clock),
        .reset_o (reset)
    );

    periph_top UUT (
        .clock         (clock),
        .reset         (reset),
        .address_i     (address),
        .data_i        (wdata),
        .io_rd_n_i     (io_rd_n),
        .io_wr_n_i     (io_wr_n),
        .mem_rd_n_i    (mem_rd_n),
        .mem_wr_n_i    (mem_wr_n),
        .aen_n_i       (aen_n),
        .dl_active_i   (dl_active),
        .dl_wr_i       (dl_wr),
        .dl_addr_i     (dl_addr),
        .dl_data_i     (dl_data),
        .keycode_i     (keycode),
        .keycode_stb_i (keycode_stb),
        .data_o        (data_out),
        .data_valid_o  (data_valid),
        .kbd_irq_o     (kbd_irq)
    );

    tb_checker #(.NAME_CHARS(NAME_CHARS)) u_checker (
        .clock_i      (clock),
        .start_i      (chk_start),
        .cycles_i     (chk_cycles),
        .row_i        (chk_row),
        .name_i       (chk_name),
        .exp_data_i   (chk_exp_data),
        .exp_valid_i  (chk_exp_valid),
        .exp_irq_i    (chk_exp_irq),
        .data_i       (data_out),
        .data_valid_i (data_valid),
        .kbd_irq_i    (kbd_irq),
        .data_errs_o  (data_errs),
        .valid_errs_o (valid_errs),
        .irq_errs_o   (irq_errs),
        .checks_o     (checks)
    );

    // one bit per step, lsb first
    function automatic logic [7:0] lfsr_byte();
        logic [7:0] b;
        for (int k = 0; k < 8; k++) begin
            b[k] = lfsr_state[0];
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
            end
            else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return b;
    endfunction

    task automatic add_row(input logic [8*NAME_CHARS-1:0] name, input int op,
                           input logic [19:0] addr, input logic [7:0] data,
                           input logic aen_hi, input logic [7:0] exp_data,
                           input logic exp_valid, input logic exp_irq);
        tab_name[row_count]      = name;
        tab_op[row_count]        = op;
        tab_addr[row_count]      = addr;
        tab_data[row_count]      = data;
        tab_aen_hi[row_count]    = aen_hi;
        tab_exp_data[row_count]  = exp_data;
        tab_exp_valid[row_count] = exp_valid;
        tab_exp_irq[row_count]   = exp_irq;
        row_count = row_count + 1;
    endtask

    task automatic build_table();
        logic [7:0] rb [0:4];
        logic [7:0] vb [0:1];
        lfsr_state = LFSR_SEED;
        for (int k = 0; k < 5; k++) begin
            rb[k] = lfsr_byte();
        end
        // text byte at offset 0x123 must differ from the RAM byte there
        vb[0] = lfsr_byte();
        while (vb[0] == rb[0]) begin
            vb[0] = lfsr_byte();
        end
        vb[1] = lfsr_byte();
        row_count = 0;
        add_row("rst_kbd_data", OP_IO_RD, 20'h00060, 8'h00, 1'b0, 8'h00, 1'b1, 1'b0);
        add_row("rst_kbd_ctrl", OP_IO_RD, 20'h00061, 8'h00, 1'b0, 8'h00, 1'b1, 1'b0);
        // system RAM at scattered addresses
        add_row("ram_wr_0", OP_MEM_WR, 20'h00123, rb[0], 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("ram_wr_1", OP_MEM_WR, 20'h12345, rb[1], 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("ram_wr_2", OP_MEM_WR, 20'h4abcd, rb[2], 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("ram_wr_3", OP_MEM_WR, 20'h7f00e, rb[3], 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("ram_wr_4", OP_MEM_WR, 20'h9ffff, rb[4], 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("ram_rd_0", OP_MEM_RD, 20'h00123, 8'h00, 1'b0, rb[0], 1'b1, 1'b0);
        add_row("ram_rd_1", OP_MEM_RD, 20'h12345, 8'h00, 1'b0, rb[1], 1'b1, 1'b0);
        add_row("ram_rd_2", OP_MEM_RD, 20'h4abcd, 8'h00, 1'b0, rb[2], 1'b1, 1'b0);
        add_row("ram_rd_3", OP_MEM_RD, 20'h7f00e, 8'h00, 1'b0, rb[3], 1'b1, 1'b0);
        add_row("ram_rd_4", OP_MEM_RD, 20'h9ffff, 8'h00, 1'b0, rb[4], 1'b1, 1'b0);
        add_row("ram_unmapped", OP_MEM_RD, 20'ha0000, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0);
        // text buffer, same low offset as ram_wr_0
        add_row("vram_wr_0", OP_MEM_WR, 20'hb0123, vb[0], 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("vram_wr_1", OP_MEM_WR, 20'hb7fff, vb[1], 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("vram_rd_0", OP_MEM_RD, 20'hb0123, 8'h00, 1'b0, vb[0], 1'b1, 1'b0);
        add_row("vram_rd_1", OP_MEM_RD, 20'hb7fff, 8'h00, 1'b0, vb[1], 1'b1, 1'b0);
        add_row("vram_ram_keep", OP_MEM_RD, 20'h00123, 8'h00, 1'b0, rb[0], 1'b1, 1'b0);
        // BIOS through the download port, address column holds the offset
        add_row("rom_load_0", OP_ROM_LOAD, 20'h00000, 8'hea, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("rom_load_1", OP_ROM_LOAD, 20'h0fff0, 8'h5b, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("rom_load_2", OP_ROM_LOAD, 20'h01234, 8'hc3, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("rom_rd_0", OP_MEM_RD, 20'hf0000, 8'h00, 1'b0, 8'hea, 1'b1, 1'b0);
        add_row("rom_rd_1", OP_MEM_RD, 20'hffff0, 8'h00, 1'b0, 8'h5b, 1'b1, 1'b0);
        add_row("rom_rd_2", OP_MEM_RD, 20'hf1234, 8'h00, 1'b0, 8'hc3, 1'b1, 1'b0);
        add_row("rom_cpu_wr", OP_MEM_WR, 20'hf1234, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("rom_rd_keep", OP_MEM_RD, 20'hf1234, 8'h00, 1'b0, 8'hc3, 1'b1, 1'b0);
        // keyboard latch, interrupt and clear bit
        add_row("key_strobe_1", OP_KEY, 20'h00000, 8'h1c, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("key_code_rd", OP_IO_RD, 20'h00060, 8'h00, 1'b0, 8'h1c, 1'b1, 1'b1);
        add_row("key_strobe_2", OP_KEY, 20'h00000, 8'h2a, 1'b0, 8'h00, 1'b0, 1'b1);
        add_row("key_second_drop", OP_IO_RD, 20'h00060, 8'h00, 1'b0, 8'h1c, 1'b1, 1'b1);
        add_row("key_clear", OP_IO_WR, 20'h00061, 8'h80, 1'b0, 8'h00, 1'b0, 1'b1);
        add_row("key_empty_rd", OP_IO_RD, 20'h00060, 8'h00, 1'b0, 8'h00, 1'b1, 1'b0);
        add_row("key_ctrl_rd", OP_IO_RD, 20'h00061, 8'h00, 1'b0, 8'h80, 1'b1, 1'b0);
        // aen high blocks every select, 0x160 is outside the I/O page
        add_row("aen_ram_wr", OP_MEM_WR, 20'h00123, ~rb[0], 1'b1, 8'h00, 1'b0, 1'b0);
        add_row("aen_ram_rd", OP_MEM_RD, 20'h00123, 8'h00, 1'b1, 8'h00, 1'b0, 1'b0);
        add_row("aen_ram_keep", OP_MEM_RD, 20'h00123, 8'h00, 1'b0, rb[0], 1'b1, 1'b0);
        add_row("aen_kbd_wr", OP_IO_WR, 20'h00061, 8'h00, 1'b1, 8'h00, 1'b0, 1'b0);
        add_row("aen_kbd_rd", OP_IO_RD, 20'h00061, 8'h00, 1'b1, 8'h00, 1'b0, 1'b0);
        add_row("aen_ctrl_keep", OP_IO_RD, 20'h00061, 8'h00, 1'b0, 8'h80, 1'b1, 1'b0);
        add_row("io_alias_160", OP_IO_RD, 20'h00160, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("io_alias_161", OP_IO_RD, 20'h00161, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("end_idle", OP_IDLE, 20'h00000, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0);
    endtask

    // called 1 ns after a rising edge, returns at the same point
    task automatic apply_row(input int idx);
        address     = tab_addr[idx];
        wdata       = tab_data[idx];
        aen_n       = tab_aen_hi[idx];
        io_rd_n     = (tab_op[idx] != OP_IO_RD);
        io_wr_n     = (tab_op[idx] != OP_IO_WR);
        mem_rd_n    = (tab_op[idx] != OP_MEM_RD);
        mem_wr_n    = (tab_op[idx] != OP_MEM_WR);
        dl_active   = (tab_op[idx] == OP_ROM_LOAD);
        dl_wr       = (tab_op[idx] == OP_ROM_LOAD);
        dl_addr     = tab_addr[idx][15:0];
        dl_data     = tab_data[idx];
        keycode     = tab_data[idx];
        keycode_stb = (tab_op[idx] == OP_KEY);
        chk_row       = idx;
        chk_name      = tab_name[idx];
        chk_exp_data  = tab_exp_data[idx];
        chk_exp_valid = tab_exp_valid[idx];
        chk_exp_irq   = tab_exp_irq[idx];
        chk_cycles    = (tab_op[idx] == OP_MEM_RD) ? 2 : 1;
        chk_start     = 1'b1;
        @(posedge clock);
        #DRIVE_DELAY;
        chk_start = 1'b0;
        if (tab_op[idx] == OP_MEM_RD) begin
            @(posedge clock);
            #DRIVE_DELAY;
        end
    endtask

    initial begin : main
        int total;
        int i;
        address     = '0;
        wdata       = '0;
        io_rd_n     = 1'b1;
        io_wr_n     = 1'b1;
        mem_rd_n    = 1'b1;
        mem_wr_n    = 1'b1;
        aen_n       = 1'b1;
        dl_active   = 1'b0;
        dl_wr       = 1'b0;
        dl_addr     = '0;
        dl_data     = '0;
        keycode     = '0;
        keycode_stb = 1'b0;
        chk_start   = 1'b0;
        chk_cycles  = 0;
        chk_row     = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        @(negedge reset);
        for (i = 0; i < row_count; i++) begin
            apply_row(i);
        end
        total = data_errs + valid_errs + irq_errs;
        if (checks != row_count) begin
            $display("only %0d of %0d table rows were checked", checks, row_count);
            total = total + 1;
        end
        $display("rows %0d, data errors %0d, valid errors %0d, irq errors %0d",
                 checks, data_errs, valid_errs, irq_errs);
        if (total == 0) begin
            $display("No errors");
        end
        else begin
            $display("Errors found");
        end
        $finish;
    end

    // every row takes at most two cycles, so three per row is ample
    initial begin : watchdog
        wait (table_ready);
        #((row_count * 3 + RESET_CYC + WD_MARGIN) * CLK_PERIOD);
        $display("timeout: the table did not finish in the expected time");
        $display("Errors found");
        $finish;
    end

endmodule
